// File: list.f
source/dbg_pkg.sv
source/uart_rx.sv
source/uart_tx.sv
source/sync_fifo.sv
source/cmd_engine.sv
source/word_ram.sv
source/dbg_tile_top.sv
sim/tb_dbg_tile.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the debug tile testbench with Verilator
set -e
set -o pipefail

cd "$(dirname "$0")"

verilator --binary --timing -f list.f --top-module tb_dbg_tile -o tb_dbg_tile

./obj_dir/tb_dbg_tile | tee sim.log

if grep -q "tests failed" sim.log; then
   echo "Simulation reported failures, see sim.log"
   exit 1
fi

echo "Simulation finished without failures"

// File: sim/tb_dbg_tile.sv
`timescale 1ns/100ps
`default_nettype none

module tb_dbg_tile
   import dbg_pkg::*;
   ();

   localparam logic [31:0] LFSR_SEED     = 32'h92bd_7b04;
   localparam int          START_TIMEOUT = 2000;
   localparam byte_t       BAD_OPCODE    = 8'h7F;
   localparam int          NUM_ADDRS     = 16;
   localparam int          NUM_B2B       = 6;

   logic        clk;
   logic        rst_i;
   logic        uart_rx_i;
   logic        uart_tx_o;
   logic        rx_overflow_o;

   logic [31:0] lfsr_state;
   word_t       sb_mem [RAM_WORDS];
   int          err_count;
   int          check_count;

   dbg_tile_top dbg_tile_top_i (
      .clk           (clk),
      .rst_i         (rst_i),
      .uart_rx_i     (uart_rx_i),
      .uart_tx_o     (uart_tx_o),
      .rx_overflow_o (rx_overflow_o)
   );

   initial begin
      clk = 1'b0;
      forever #50 clk = ~clk;
   end

   // Taps 32, 22, 2, 1
   function automatic logic [31:0] lfsr_next(input logic [31:0] s);
      logic fb;
      fb = s[31] ^ s[21] ^ s[1] ^ s[0];
      return {s[30:0], fb};
   endfunction

   task automatic get_random(input int nbits, output word_t value);
      value = '0;
      for (int i = 0; i < nbits; i++) begin
         lfsr_state = lfsr_next(lfsr_state);
         value = {value[30:0], lfsr_state[0]};
      end
   endtask

   task automatic check_value(input string name, input word_t exp, input word_t got);
      check_count++;
      if (got !== exp) begin
         $display("MISMATCH %s: expected %h, got %h", name, exp, got);
         err_count++;
      end
   endtask

   // Host side UART frame, start bit, LSB first, stop bit
   task automatic send_byte(input byte_t b);
      logic [9:0] frame;
      frame = {1'b1, b, 1'b0};
      for (int i = 0; i < 10; i++) begin
         @(posedge clk);
         uart_rx_i <= frame[i];
         repeat (CLKS_PER_BIT - 1) @(posedge clk);
      end
   endtask

   task automatic send_write(input logic [15:0] adr, input word_t data);
      send_byte(OP_WRITE);
      send_byte(adr[7:0]);
      send_byte(adr[15:8]);
      for (int i = 0; i < 4; i++)
         send_byte(data[8*i +: 8]);
   endtask

   task automatic send_read(input logic [15:0] adr);
      send_byte(OP_READ);
      send_byte(adr[7:0]);
      send_byte(adr[15:8]);
   endtask

   // Four frames from uart_tx_o, sampled at mid-bit on the falling edge
   task automatic recv_word(output word_t word, output logic ok);
      int    waited;
      byte_t rx_b;
      word = '0;
      ok   = 1'b1;
      for (int n = 0; n < 4; n++) begin
         waited = 0;
         @(negedge clk);
         while (uart_tx_o !== 1'b0 && waited < START_TIMEOUT) begin
            @(negedge clk);
            waited++;
         end
         if (uart_tx_o !== 1'b0) begin
            $display("Timeout waiting for the start bit of byte %0d on uart_tx_o", n);
            err_count++;
            ok = 1'b0;
            return;
         end
         repeat (CLKS_PER_BIT / 2) @(negedge clk);
         if (uart_tx_o !== 1'b0) begin
            $display("Start bit of byte %0d on uart_tx_o is not low at its middle", n);
            err_count++;
            ok = 1'b0;
            return;
         end
         for (int b = 0; b < 8; b++) begin
            repeat (CLKS_PER_BIT) @(negedge clk);
            rx_b[b] = uart_tx_o;
         end
         repeat (CLKS_PER_BIT) @(negedge clk);
         if (uart_tx_o !== 1'b1) begin
            $display("Stop bit of byte %0d on uart_tx_o is low", n);
            err_count++;
            ok = 1'b0;
         end
         word[8*n +: 8] = rx_b;
      end
   endtask

   task automatic write_word(input logic [15:0] adr, input word_t data);
      send_write(adr, data);
      sb_mem[adr[RAM_AW-1:0]] = data;
   endtask

   // Response can start before the last command byte is finished
   task automatic read_and_check(input logic [15:0] adr);
      word_t got;
      logic  ok;
      fork
         send_read(adr);
         recv_word(got, ok);
      join
      if (ok)
         check_value("uart_tx_o read word", sb_mem[adr[RAM_AW-1:0]], got);
   endtask

   task automatic test_write_read();
      word_t r;
      word_t data;
      logic [15:0] adr;
      get_random(RAM_AW, r);
      adr = 16'(r[RAM_AW-1:0]);
      get_random(32, data);
      write_word(adr, data);
      read_and_check(adr);
   endtask

   task automatic test_many_addresses();
      logic [15:0] adrs [NUM_ADDRS];
      word_t       r;
      word_t       data;
      for (int i = 0; i < NUM_ADDRS; i++) begin
         get_random(RAM_AW, r);
         adrs[i] = 16'(r[RAM_AW-1:0]);
         get_random(32, data);
         write_word(adrs[i], data);
      end
      for (int i = 0; i < NUM_ADDRS; i++)
         read_and_check(adrs[i]);
   endtask

   task automatic test_alias();
      word_t       r;
      word_t       data;
      logic [15:0] adr;
      get_random(RAM_AW, r);
      adr = 16'(r[RAM_AW-1:0]);
      get_random(32, data);
      // Bit 6 and up are dropped by the engine
      send_write(adr + 16'd64, data);
      sb_mem[adr[RAM_AW-1:0]] = data;
      read_and_check(adr);
   endtask

   task automatic test_bad_opcode();
      word_t       r;
      word_t       data;
      word_t       got_err;
      word_t       got_rd;
      logic        ok_err;
      logic        ok_rd;
      logic [15:0] adr;
      get_random(RAM_AW, r);
      adr = 16'(r[RAM_AW-1:0]);
      get_random(32, data);
      write_word(adr, data);
      fork
         begin
            send_byte(BAD_OPCODE);
            send_read(adr);
         end
         begin
            recv_word(got_err, ok_err);
            recv_word(got_rd, ok_rd);
         end
      join
      if (ok_err)
         check_value("uart_tx_o error word", ERR_WORD, got_err);
      if (ok_rd)
         check_value("uart_tx_o read word", sb_mem[adr[RAM_AW-1:0]], got_rd);
   endtask

   task automatic test_back_to_back();
      logic [15:0] adrs [NUM_B2B];
      word_t       got  [NUM_B2B];
      logic        ok   [NUM_B2B];
      word_t       r;
      word_t       data;
      for (int i = 0; i < NUM_B2B; i++) begin
         get_random(RAM_AW, r);
         adrs[i] = 16'(r[RAM_AW-1:0]);
         get_random(32, data);
         write_word(adrs[i], data);
      end
      fork
         for (int i = 0; i < NUM_B2B; i++)
            send_read(adrs[i]);
         for (int i = 0; i < NUM_B2B; i++)
            recv_word(got[i], ok[i]);
      join
      for (int i = 0; i < NUM_B2B; i++) begin
         if (ok[i])
            check_value("uart_tx_o read word", sb_mem[adrs[i][RAM_AW-1:0]], got[i]);
      end
      check_value("rx_overflow_o", 32'h0, 32'(rx_overflow_o));
   endtask

   initial begin
      err_count   = 0;
      check_count = 0;
      lfsr_state  = LFSR_SEED;
      rst_i       = 1'b1;
      uart_rx_i   = 1'b1;

      repeat (10) @(posedge clk);
      rst_i <= 1'b0;
      @(negedge clk);
      // Idle line and clear flag out of reset
      check_value("uart_tx_o", 32'h1, 32'(uart_tx_o));
      check_value("rx_overflow_o", 32'h0, 32'(rx_overflow_o));
      repeat (4) @(posedge clk);

      test_write_read();
      test_many_addresses();
      test_alias();
      test_bad_opcode();
      test_back_to_back();

      $display("Checks: %0d, errors: %0d", check_count, err_count);
      if (err_count == 0)
         $display("all tests passed");
      else
         $display("tests failed");
      $finish;
   end

endmodule

`default_nettype wire

// File: source/dbg_tile_top.sv
`timescale 1ns/100ps
`default_nettype none

module dbg_tile_top
   import dbg_pkg::*;
   (
   input  logic clk,
   input  logic rst_i,

   // Host UART, idle high in both directions
   input  logic uart_rx_i,
   output logic uart_tx_o,

   output logic rx_overflow_o
   );

   byte_t rx_byte;
   logic  rx_strobe;

   byte_t cmd_data;
   logic  cmd_empty;
   logic  cmd_full;
   logic  cmd_pop;

   logic  bus_stb;
   logic  bus_we;
   addr_t bus_adr;
   word_t bus_wdat;
   word_t bus_rdat;
   logic  bus_ack;

   word_t rsp_wdata;
   word_t rsp_rdata;
   logic  rsp_push;
   logic  rsp_pop;
   logic  rsp_empty;
   logic  rsp_full;

   uart_rx u_uart_rx (
      .clk      (clk),
      .rst_i    (rst_i),
      .rx_i     (uart_rx_i),
      .data_o   (rx_byte),
      .strobe_o (rx_strobe)
   );

   // Byte lost when the command FIFO is full, flag stays until reset
   always_ff @(posedge clk) begin
      if (rst_i)
         rx_overflow_o <= 1'b0;
      else if (rx_strobe && cmd_full)
         rx_overflow_o <= 1'b1;
   end

   sync_fifo #(
      .DEPTH (CMD_FIFO_DEPTH),
      .T     (byte_t)
   ) cmd_fifo (
      .clk     (clk),
      .rst_i   (rst_i),
      .push_i  (rx_strobe),
      .data_i  (rx_byte),
      .pop_i   (cmd_pop),
      .data_o  (cmd_data),
      .empty_o (cmd_empty),
      .full_o  (cmd_full)
   );

   cmd_engine u_cmd_engine (
      .clk         (clk),
      .rst_i       (rst_i),
      .cmd_data_i  (cmd_data),
      .cmd_empty_i (cmd_empty),
      .cmd_pop_o   (cmd_pop),
      .bus_stb_o   (bus_stb),
      .bus_we_o    (bus_we),
      .bus_adr_o   (bus_adr),
      .bus_wdat_o  (bus_wdat),
      .bus_rdat_i  (bus_rdat),
      .bus_ack_i   (bus_ack),
      .rsp_full_i  (rsp_full),
      .rsp_push_o  (rsp_push),
      .rsp_data_o  (rsp_wdata)
   );

   word_ram u_word_ram (
      .clk    (clk),
      .rst_i  (rst_i),
      .stb_i  (bus_stb),
      .we_i   (bus_we),
      .adr_i  (bus_adr),
      .wdat_i (bus_wdat),
      .rdat_o (bus_rdat),
      .ack_o  (bus_ack)
   );

   sync_fifo #(
      .DEPTH (RSP_FIFO_DEPTH),
      .T     (word_t)
   ) rsp_fifo (
      .clk     (clk),
      .rst_i   (rst_i),
      .push_i  (rsp_push),
      .data_i  (rsp_wdata),
      .pop_i   (rsp_pop),
      .data_o  (rsp_rdata),
      .empty_o (rsp_empty),
      .full_o  (rsp_full)
   );

   uart_tx u_uart_tx (
      .clk     (clk),
      .rst_i   (rst_i),
      .word_i  (rsp_rdata),
      .empty_i (rsp_empty),
      .pop_o   (rsp_pop),
      .tx_o    (uart_tx_o)
   );

endmodule

`default_nettype wire

// File: source/word_ram.sv
`timescale 1ns/100ps
`default_nettype none

module word_ram
   import dbg_pkg::*;
   (
   input  logic  clk,
   input  logic  rst_i,
   input  logic  stb_i,
   input  logic  we_i,
   input  addr_t adr_i,
   input  word_t wdat_i,
   output word_t rdat_o,
   output logic  ack_o
   );

   word_t mem [RAM_WORDS];
   logic  access;

   // New request only, the held strobe during ack is ignored
   assign access = stb_i && !ack_o;

   always_ff @(posedge clk) begin
      if (rst_i)
         ack_o <= 1'b0;
      else
         ack_o <= access;
   end

   // Read data comes out together with the ack
   always_ff @(posedge clk) begin
      if (access) begin
         if (we_i)
            mem[adr_i] <= wdat_i;
         rdat_o <= mem[adr_i];
      end
   end

endmodule

`default_nettype wire

// File: source/cmd_engine.sv
`timescale 1ns/100ps
`default_nettype none

module cmd_engine
   import dbg_pkg::*;
   (
   input  logic  clk,
   input  logic  rst_i,

   // Command byte FIFO
   input  byte_t cmd_data_i,
   input  logic  cmd_empty_i,
   output logic  cmd_pop_o,

   // Memory bus, master side
   output logic  bus_stb_o,
   output logic  bus_we_o,
   output addr_t bus_adr_o,
   output word_t bus_wdat_o,
   input  word_t bus_rdat_i,
   input  logic  bus_ack_i,

   // Response word FIFO
   input  logic  rsp_full_i,
   output logic  rsp_push_o,
   output word_t rsp_data_o
   );

   typedef enum logic [2:0] {
      S_OP,
      S_ADR_LO,
      S_ADR_HI,
      S_DAT,
      S_BUS,
      S_ACK,
      S_ERR
   } state_t;

   state_t     state;
   logic [1:0] dat_cnt;
   byte_t      adr_lo;

   // One byte per cycle in the parsing states
   always_comb begin
      case (state)
         S_OP, S_ADR_LO, S_ADR_HI, S_DAT: cmd_pop_o = !cmd_empty_i;
         default:                         cmd_pop_o = 1'b0;
      endcase
   end

   always_ff @(posedge clk) begin
      if (rst_i) begin
         state      <= S_OP;
         dat_cnt    <= '0;
         bus_stb_o  <= 1'b0;
         bus_we_o   <= 1'b0;
         rsp_push_o <= 1'b0;
      end else begin
         rsp_push_o <= 1'b0;
         case (state)
            S_OP: begin
               if (cmd_pop_o) begin
                  bus_we_o <= (cmd_data_i == OP_WRITE);
                  if (cmd_data_i == OP_WRITE || cmd_data_i == OP_READ)
                     state <= S_ADR_LO;
                  else
                     state <= S_ERR;
               end
            end
            S_ADR_LO: begin
               if (cmd_pop_o)
                  state <= S_ADR_HI;
            end
            S_ADR_HI: begin
               if (cmd_pop_o) begin
                  dat_cnt <= '0;
                  state   <= bus_we_o ? S_DAT : S_BUS;
               end
            end
            S_DAT: begin
               if (cmd_pop_o) begin
                  dat_cnt <= dat_cnt + 1'b1;
                  if (dat_cnt == 2'd3)
                     state <= S_BUS;
               end
            end
            S_BUS: begin
               // A read only starts once its answer has a slot
               if (bus_we_o || !rsp_full_i) begin
                  bus_stb_o <= 1'b1;
                  state     <= S_ACK;
               end
            end
            S_ACK: begin
               if (bus_ack_i) begin
                  bus_stb_o  <= 1'b0;
                  rsp_push_o <= !bus_we_o;
                  state      <= S_OP;
               end
            end
            S_ERR: begin
               if (!rsp_full_i) begin
                  rsp_push_o <= 1'b1;
                  state      <= S_OP;
               end
            end
            default: state <= S_OP;
         endcase
      end
   end

   // Little-endian assembly of address and write data
   always_ff @(posedge clk) begin
      if (state == S_ADR_LO && cmd_pop_o)
         adr_lo <= cmd_data_i;
      if (state == S_ADR_HI && cmd_pop_o)
         bus_adr_o <= addr_t'({cmd_data_i, adr_lo});
      if (state == S_DAT && cmd_pop_o)
         bus_wdat_o <= {cmd_data_i, bus_wdat_o[31:8]};
   end

   always_ff @(posedge clk) begin
      if (state == S_ACK && bus_ack_i)
         rsp_data_o <= bus_rdat_i;
      else if (state == S_ERR)
         rsp_data_o <= ERR_WORD;
   end

endmodule

`default_nettype wire

// File: source/sync_fifo.sv
`timescale 1ns/100ps
`default_nettype none

// DEPTH must be a power of two, the pointers wrap on their own
module sync_fifo
   import dbg_pkg::*;
   #(
   parameter int  DEPTH = 4,
   parameter type T     = byte_t
   )
   (
   input  logic clk,
   input  logic rst_i,
   input  logic push_i,
   input  T     data_i,
   input  logic pop_i,
   output T     data_o,
   output logic empty_o,
   output logic full_o
   );

   T                           mem [DEPTH];
   logic [$clog2(DEPTH)-1:0]   wr_ptr;
   logic [$clog2(DEPTH)-1:0]   rd_ptr;
   logic [$clog2(DEPTH):0]     count;
   logic                       do_push;
   logic                       do_pop;

   assign do_push = push_i && !full_o;
   assign do_pop  = pop_i && !empty_o;

   assign empty_o = (count == '0);
   // Top bit of the count is set only at DEPTH entries
   assign full_o  = count[$clog2(DEPTH)];
   assign data_o  = mem[rd_ptr];

   always_ff @(posedge clk) begin
      if (rst_i) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (do_push)
            wr_ptr <= wr_ptr + 1'b1;
         if (do_pop)
            rd_ptr <= rd_ptr + 1'b1;
         case ({do_push, do_pop})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (do_push)
         mem[wr_ptr] <= data_i;
   end

endmodule

`default_nettype wire

// File: source/uart_tx.sv
`timescale 1ns/100ps
`default_nettype none

module uart_tx
   import dbg_pkg::*;
   (
   input  logic  clk,
   input  logic  rst_i,
   input  word_t word_i,
   input  logic  empty_i,
   output logic  pop_o,
   output logic  tx_o
   );

   logic       busy;
   bit_cnt_t   clk_cnt;
   logic [3:0] bit_idx;
   logic [1:0] byte_idx;
   logic [9:0] frame;
   word_t      word_q;
   logic       frame_done;

   // Head of the FIFO is taken whenever the shifter is free
   assign pop_o = !busy && !empty_i;
   assign tx_o  = frame[0];

   assign frame_done = busy && clk_cnt == BIT_LAST && bit_idx == 4'd9;

   always_ff @(posedge clk) begin
      if (rst_i) begin
         busy     <= 1'b0;
         frame    <= '1;
         clk_cnt  <= '0;
         bit_idx  <= '0;
         byte_idx <= '0;
      end else if (pop_o) begin
         busy     <= 1'b1;
         frame    <= {1'b1, word_i[7:0], 1'b0};
         clk_cnt  <= '0;
         bit_idx  <= '0;
         byte_idx <= '0;
      end else if (busy) begin
         clk_cnt <= clk_cnt + 1'b1;
         if (clk_cnt == BIT_LAST) begin
            bit_idx <= bit_idx + 1'b1;
            frame   <= {1'b1, frame[9:1]};
            if (bit_idx == 4'd9) begin
               bit_idx  <= '0;
               byte_idx <= byte_idx + 1'b1;
               // Next byte follows the stop bit directly
               if (byte_idx == 2'd3)
                  busy <= 1'b0;
               else
                  frame <= {1'b1, word_q[15:8], 1'b0};
            end
         end
      end
   end

   always_ff @(posedge clk) begin
      if (pop_o)
         word_q <= word_i;
      else if (frame_done)
         word_q <= word_q >> 8;
   end

endmodule

`default_nettype wire

// File: source/uart_rx.sv
`timescale 1ns/100ps
`default_nettype none

module uart_rx
   import dbg_pkg::*;
   (
   input  logic  clk,
   input  logic  rst_i,
   input  logic  rx_i,
   output byte_t data_o,
   output logic  strobe_o
   );

   typedef enum logic [1:0] {RX_IDLE, RX_START, RX_DATA, RX_STOP} rx_state_t;

   rx_state_t  state;
   logic       rx_meta;
   logic       rx_sync;
   bit_cnt_t   clk_cnt;
   logic [2:0] bit_idx;

   // Line is asynchronous to clk
   always_ff @(posedge clk) begin
      if (rst_i) begin
         rx_meta <= 1'b1;
         rx_sync <= 1'b1;
      end else begin
         rx_meta <= rx_i;
         rx_sync <= rx_meta;
      end
   end

   always_ff @(posedge clk) begin
      if (rst_i) begin
         state    <= RX_IDLE;
         clk_cnt  <= '0;
         bit_idx  <= '0;
         strobe_o <= 1'b0;
      end else begin
         strobe_o <= 1'b0;
         clk_cnt  <= clk_cnt + 1'b1;
         case (state)
            RX_IDLE: begin
               clk_cnt <= '0;
               if (!rx_sync)
                  state <= RX_START;
            end
            RX_START: begin
               // Glitch shorter than half a bit goes back to idle
               if (clk_cnt == HALF_BIT_LAST) begin
                  clk_cnt <= '0;
                  bit_idx <= '0;
                  state   <= rx_sync ? RX_IDLE : RX_DATA;
               end
            end
            RX_DATA: begin
               if (clk_cnt == BIT_LAST) begin
                  bit_idx <= bit_idx + 1'b1;
                  if (bit_idx == 3'd7)
                     state <= RX_STOP;
               end
            end
            RX_STOP: begin
               // Middle of the stop bit, framing error drops the byte
               if (clk_cnt == BIT_LAST) begin
                  strobe_o <= rx_sync;
                  state    <= RX_IDLE;
               end
            end
            default: state <= RX_IDLE;
         endcase
      end
   end

   // LSB arrives first
   always_ff @(posedge clk) begin
      if (state == RX_DATA && clk_cnt == BIT_LAST)
         data_o <= {rx_sync, data_o[7:1]};
   end

endmodule

`default_nettype wire

// File: source/dbg_pkg.sv
`default_nettype none

package dbg_pkg;

   // UART bit timing
   localparam int CLKS_PER_BIT = 8;
   localparam int BIT_CNT_W = $clog2(CLKS_PER_BIT);

   typedef logic [BIT_CNT_W-1:0] bit_cnt_t;

   // Last cycle of a bit, and last cycle before the middle of a bit
   localparam bit_cnt_t BIT_LAST = bit_cnt_t'(CLKS_PER_BIT - 1);
   localparam bit_cnt_t HALF_BIT_LAST = bit_cnt_t'(CLKS_PER_BIT / 2 - 1);

   typedef logic [7:0]  byte_t;
   typedef logic [31:0] word_t;

   // Local word memory
   localparam int RAM_AW = 6;
   localparam int RAM_WORDS = 1 << RAM_AW;

   typedef logic [RAM_AW-1:0] addr_t;

   // Host command opcodes
   localparam byte_t OP_WRITE = 8'h01;
   localparam byte_t OP_READ  = 8'h02;

   // Returned for any unknown opcode
   localparam word_t ERR_WORD = 32'hDEAD_BEEF;

   localparam int CMD_FIFO_DEPTH = 16;
   localparam int RSP_FIFO_DEPTH = 4;

endpackage

`default_nettype wire
